//--- filelist.f
+incdir+include
hw/fetch_pkg.sv
hw/prefetch_fsm.sv
hw/outstanding_counter.sv
hw/align_buffer.sv
hw/fetch_top.sv
tests/fetch_props.sv
tests/fetch_tb.sv

//--- Makefile
SIM       = verilator
SIM_FLAGS = --binary --timing --assert -j 0
TOP       = fetch_tb
FILELIST  = filelist.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q ">>> FAIL" $(LOG) || ! grep -q ">>> PASS" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tests/fetch_tb.sv
//////////////////////////////////////////////////////////////////////
// Directed testbench for the fetch front end. The memory model covers
// 2 KB and wraps above that, so every test stream stays below 0x800
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "fetch_defines.svh"

module fetch_tb
  import fetch_pkg::*;
();

  logic                     clk;
  logic                     rst_n;
  fetch_ctrl_t              ctrl;
  logic                     mem_req;
  logic [`FETCH_ADDR_W-1:0] mem_addr;
  logic                     mem_gnt;
  logic                     mem_rvalid;
  inst_resp_t               mem_resp;
  logic                     id_ready;
  logic                     instr_valid;
  instr_out_t               instr;

  int          seed;
  int          mismatches;
  int          timeouts;
  int          other_fails;
  int          cyc;
  // Granted reads minus responses, as seen on the memory pins
  int          outst;
  int          gnt_pct;
  logic [15:0] mem [0:1023];
  logic        err_en;
  // Word index that answers with bus_err
  logic [8:0]  err_word;
  logic [31:0] exp_pc;
  // Address just past the most recently granted word
  logic [31:0] gnt_end;
  logic [31:0] rsp_addr;
  logic [31:0] rsp_addr_q [$];
  int          rsp_due_q [$];

  fetch_top UUT (
    .clk           (clk),
    .rst_n         (rst_n),
    .fetch_ctrl_i  (ctrl),
    .mem_req_o     (mem_req),
    .mem_addr_o    (mem_addr),
    .mem_gnt_i     (mem_gnt),
    .mem_rvalid_i  (mem_rvalid),
    .mem_resp_i    (mem_resp),
    .id_ready_i    (id_ready),
    .instr_valid_o (instr_valid),
    .instr_o       (instr)
  );

  always #4 clk = ~clk;

  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  // Halfword pattern with both 16-bit and 32-bit encodings
  task automatic fill_memory();
    logic [9:0] hw_idx;
    for (int i = 0; i < 1024; i++) begin
      hw_idx = i[9:0];
      mem[i] = {hw_idx ^ 10'h2B7, hw_idx[5:2], (i % 3 == 0) ? 2'b11 : (hw_idx[1:0] ^ 2'b01)};
    end
  endtask

  // Reference decoder that walks the memory array by the length rule
  function automatic instr_out_t expected_instr(input logic [31:0] a);
    instr_out_t  r;
    logic [31:0] a_hi;
    logic [15:0] lo;
    logic [15:0] hi;
    a_hi         = a + 32'd2;
    lo           = mem[a[10:1]];
    hi           = mem[a_hi[10:1]];
    r.addr       = a;
    r.compressed = (lo[1:0] != 2'b11);
    r.instr      = r.compressed ? {16'h0000, lo} : {hi, lo};
    r.bus_err    = err_en && ((a[10:2] == err_word) ||
                              (!r.compressed && (a_hi[10:2] == err_word)));
    return r;
  endfunction

  ////////////////////////////////////////////////////////////////////
  // Memory model
  ////////////////////////////////////////////////////////////////////

  // Grants are recorded on the rising edge with a latency of 1 to 3
  always @(posedge clk) begin
    cyc = cyc + 1;
    if (rst_n) begin
      if (mem_req && mem_gnt) begin
        rsp_addr_q.push_back(mem_addr);
        rsp_due_q.push_back(cyc + rand_below(3));
        gnt_end = mem_addr + 32'd4;
        outst++;
      end
      if (mem_rvalid) outst--;
      if (outst > `FETCH_MAX_OUTST) begin
        other_fails++;
        $display("more than two reads outstanding at %0t", $time);
      end
    end
  end

  // Responses leave in grant order on the falling edge
  always @(negedge clk) begin
    mem_gnt    = (rand_below(100) < gnt_pct);
    mem_rvalid = 1'b0;
    if (rsp_due_q.size() > 0 && rsp_due_q[0] <= cyc) begin
      rsp_addr = rsp_addr_q.pop_front();
      void'(rsp_due_q.pop_front());
      mem_rvalid       = 1'b1;
      mem_resp.rdata   = {mem[{rsp_addr[10:2], 1'b1}], mem[{rsp_addr[10:2], 1'b0}]};
      mem_resp.bus_err = err_en && (rsp_addr[10:2] == err_word);
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Checks and stimulus helpers
  ////////////////////////////////////////////////////////////////////

  task automatic check_instr(input instr_out_t got, input instr_out_t exp);
    if (got !== exp) begin
      mismatches++;
      $display("mismatch at %0t: instr_o got %h/%h/%b/%b expected %h/%h/%b/%b", $time,
               got.instr, got.addr, got.compressed, got.bus_err,
               exp.instr, exp.addr, exp.compressed, exp.bus_err);
    end
  endtask

  task automatic check_addr(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    if (got !== exp) begin
      mismatches++;
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // One cycle pc_set pulse, with the request address checked in that cycle
  task automatic branch_to(input logic [31:0] target);
    @(negedge clk);
    ctrl.instr_req   = 1'b1;
    ctrl.pc_set      = 1'b1;
    ctrl.branch_addr = target;
    exp_pc           = target;
    #1;
    check_addr("mem_addr_o", mem_addr, {target[31:2], 2'b00});
    @(negedge clk);
    ctrl.pc_set = 1'b0;
  endtask

  // Decode side for one cycle, sampled after the falling edge settles
  task automatic decode_step(input int ready_pct, output bit took);
    instr_out_t exp;
    @(negedge clk);
    id_ready = (rand_below(100) < ready_pct);
    #1;
    took = instr_valid && id_ready;
    if (took) begin
      exp = expected_instr(exp_pc);
      check_instr(instr, exp);
      exp_pc = exp_pc + (exp.compressed ? 32'd2 : 32'd4);
    end
  endtask

  task automatic run_stream(input logic [31:0] target, input int n, input int ready_pct);
    int got;
    int idle;
    bit took;
    got  = 0;
    idle = 0;
    branch_to(target);
    while (got < n && idle < 100) begin
      decode_step(ready_pct, took);
      if (took) begin
        got++;
        idle = 0;
      end else begin
        idle++;
      end
    end
    if (got < n) begin
      timeouts++;
      $display("timeout after %0d instructions from target %h", got, target);
    end
  endtask

  ////////////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////////////

  task automatic sequential_fetch();
    run_stream(32'h0000_0100, 20, 100);
  endtask

  // Halfword 0x105 ends in 2'b11, so the first instruction straddles
  task automatic unaligned_target();
    run_stream(32'h0000_020A, 4, 100);
  endtask

  task automatic branch_in_traffic();
    int n;
    run_stream(32'h0000_0040, 5, 100);
    // A read counted after a rising edge is still in flight at the next falling edge
    n = 0;
    @(posedge clk);
    #1;
    while (outst == 0 && n < 50) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (outst == 0) begin
      timeouts++;
      $display("timeout waiting for reads in flight before the branch");
    end
    // Stale words from 0x40 onward would break the match at 0x480
    run_stream(32'h0000_0480, 10, 100);
  endtask

  task automatic backpressure_stream();
    run_stream(32'h0000_0600, 40, 50);
  endtask

  task automatic bus_error_marking();
    err_word = 9'h0C2;
    err_en   = 1'b1;
    run_stream(32'h0000_0300, 12, 100);
    err_en   = 1'b0;
  endtask

  task automatic fetch_stop_drain();
    int         n;
    int         drained;
    bit         took;
    instr_out_t nxt;
    branch_to(32'h0000_0700);
    id_ready = 1'b0;
    n = 0;
    while (!instr_valid && n < 50) begin
      @(negedge clk);
      #1;
      n++;
    end
    if (!instr_valid) begin
      timeouts++;
      $display("timeout waiting for a buffered instruction before fetch stop");
    end
    @(negedge clk);
    ctrl.instr_req = 1'b0;
    n = 0;
    while (outst != 0 && n < 50) begin
      @(negedge clk);
      n++;
    end
    if (outst != 0) begin
      timeouts++;
      $display("timeout waiting for pending responses after fetch stop");
    end
    drained = 0;
    for (int i = 0; i < 30; i++) begin
      decode_step(100, took);
      if (took) drained++;
      if (mem_req) begin
        other_fails++;
        $display("memory request at %0t while fetching is stopped", $time);
      end
    end
    if (drained == 0) begin
      other_fails++;
      $display("no buffered instruction drained after fetch stop");
    end
    // Every instruction that lies wholly in fetched words must have drained
    nxt = expected_instr(exp_pc);
    if (exp_pc + (nxt.compressed ? 32'd2 : 32'd4) <= gnt_end) begin
      other_fails++;
      $display("instruction at %h was fetched but never drained", exp_pc);
    end
  endtask

  initial begin
    seed        = 84302;
    mismatches  = 0;
    timeouts    = 0;
    other_fails = 0;
    cyc         = 0;
    outst       = 0;
    gnt_pct     = 70;
    err_en      = 1'b0;
    err_word    = '0;
    exp_pc      = '0;
    gnt_end     = '0;
    clk         = 1'b0;
    rst_n       = 1'b0;
    ctrl        = '0;
    mem_gnt     = 1'b0;
    mem_rvalid  = 1'b0;
    mem_resp    = '0;
    id_ready    = 1'b0;
    fill_memory();
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    sequential_fetch();
    unaligned_target();
    branch_in_traffic();
    backpressure_stream();
    bus_error_marking();
    fetch_stop_drain();
    $display("checks failed: %0d mismatches, %0d timeouts, %0d other",
             mismatches, timeouts, other_fails);
    if (mismatches == 0 && timeouts == 0 && other_fails == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- tests/fetch_props.sv
//////////////////////////////////////////////////////////////////////
// Concurrent checks bound into fetch_top. The buffer fill is taken
// from the align_buffer instance u_align
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "fetch_defines.svh"

module fetch_props
  import fetch_pkg::*;
(
  input logic                     clk,
  input logic                     rst_n,
  input fetch_ctrl_t              fetch_ctrl_i,
  input logic [`FETCH_ADDR_W-1:0] mem_addr_i,
  input logic                     instr_valid_i,
  input logic [1:0]               outst_cnt_i,
  input logic [1:0]               buf_cnt_i
);

  // Words held plus reads in flight must fit in the three buffer words
  buf_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    ({1'b0, buf_cnt_i} + {1'b0, outst_cnt_i}) <= `FETCH_BUF_WORDS)
    else $error("alignment buffer can be overrun by reads in flight");

  // A branch empties the buffer by the next cycle
  buf_empty_after_branch: assert property (@(posedge clk) disable iff (!rst_n)
    fetch_ctrl_i.pc_set |=> (buf_cnt_i == 2'd0))
    else $error("alignment buffer not empty after a branch");

  // Nothing goes to decode in the branch cycle
  no_valid_at_branch: assert property (@(posedge clk) disable iff (!rst_n)
    fetch_ctrl_i.pc_set |-> !instr_valid_i)
    else $error("instruction offered during a branch");

  // Memory is always addressed by whole words
  addr_aligned_at_branch: assert property (@(posedge clk) disable iff (!rst_n)
    fetch_ctrl_i.pc_set |-> (mem_addr_i[1:0] == 2'b00))
    else $error("request address not word aligned at a branch");

  outst_in_limit: assert property (@(posedge clk) disable iff (!rst_n)
    outst_cnt_i <= `FETCH_MAX_OUTST)
    else $error("outstanding read count above the limit");

endmodule

bind fetch_top fetch_props u_props (
  .clk           (clk),
  .rst_n         (rst_n),
  .fetch_ctrl_i  (fetch_ctrl_i),
  .mem_addr_i    (mem_addr_o),
  .instr_valid_i (instr_valid_o),
  .outst_cnt_i   (outst_cnt),
  .buf_cnt_i     (u_align.cnt_q)
);

//--- hw/fetch_top.sv
//////////////////////////////////////////////////////////////////////
// Fetch front end. pc_set is legal only while instr_req is high and
// memory must return responses in grant order
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "fetch_defines.svh"

module fetch_top
  import fetch_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst_n,
  input  fetch_ctrl_t              fetch_ctrl_i,
  // Instruction memory
  output logic                     mem_req_o,
  output logic [`FETCH_ADDR_W-1:0] mem_addr_o,
  input  logic                     mem_gnt_i,
  input  logic                     mem_rvalid_i,
  input  inst_resp_t               mem_resp_i,
  // Decode stage
  input  logic                     id_ready_i,
  output logic                     instr_valid_o,
  output instr_out_t               instr_o
);

  logic [1:0] outst_cnt;
  logic       rvalid_gated;
  logic       fetch_room;

  // Read issue toward memory
  prefetch_fsm u_prefetch (
    .clk          (clk),
    .rst_n        (rst_n),
    .fetch_ctrl_i (fetch_ctrl_i),
    .fetch_room_i (fetch_room),
    .mem_gnt_i    (mem_gnt_i),
    .mem_req_o    (mem_req_o),
    .mem_addr_o   (mem_addr_o)
  );

  // Read tracking and stale response filter
  outstanding_counter u_outst (
    .clk            (clk),
    .rst_n          (rst_n),
    .mem_req_i      (mem_req_o),
    .mem_gnt_i      (mem_gnt_i),
    .mem_rvalid_i   (mem_rvalid_i),
    .pc_set_i       (fetch_ctrl_i.pc_set),
    .outst_cnt_o    (outst_cnt),
    .rvalid_gated_o (rvalid_gated)
  );

  // Word to instruction alignment
  align_buffer u_align (
    .clk           (clk),
    .rst_n         (rst_n),
    .fetch_ctrl_i  (fetch_ctrl_i),
    .rvalid_i      (rvalid_gated),
    .resp_i        (mem_resp_i),
    .outst_cnt_i   (outst_cnt),
    .id_ready_i    (id_ready_i),
    .fetch_room_o  (fetch_room),
    .instr_valid_o (instr_valid_o),
    .instr_o       (instr_o)
  );

endmodule

//--- hw/align_buffer.sv
//////////////////////////////////////////////////////////////////////
// Three-word FIFO that cuts 16-bit and 32-bit instructions out of the
// word stream. Room is withheld so a granted read always has a slot
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "fetch_defines.svh"

module align_buffer
  import fetch_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  fetch_ctrl_t fetch_ctrl_i,
  input  logic        rvalid_i,
  input  inst_resp_t  resp_i,
  input  logic [1:0]  outst_cnt_i,
  input  logic        id_ready_i,
  output logic        fetch_room_o,
  output logic        instr_valid_o,
  output instr_out_t  instr_o
);

  // Entry 0 is always the oldest word
  inst_resp_t               buf_q [`FETCH_BUF_WORDS];
  logic [1:0]               cnt_q;
  // Halfword of entry 0 where the next instruction starts
  logic                     hptr_q;
  logic [`FETCH_ADDR_W-1:0] addr_q;

  logic [15:0]              hw_lo;
  logic [15:0]              hw_hi;
  logic                     compr;
  logic                     avail;
  logic                     consume;
  logic                     pop;
  logic                     push;
  logic [1:0]               wr_idx;
  logic [2:0]               fill;

  ////////////////////////////////////////////////////////////////////
  // Instruction extraction
  ////////////////////////////////////////////////////////////////////

  // First halfword of the instruction
  assign hw_lo = hptr_q ? buf_q[0].rdata[31:16] : buf_q[0].rdata[15:0];
  // Second halfword, which comes from the next word on a straddle
  assign hw_hi = hptr_q ? buf_q[1].rdata[15:0] : buf_q[0].rdata[31:16];

  // Only the low two bits decide the length
  assign compr = (hw_lo[1:0] != 2'b11);

  // A straddling 32-bit instruction needs two words in the buffer
  always_comb begin
    if (compr || !hptr_q) avail = (cnt_q != 2'd0);
    else avail = (cnt_q >= 2'd2);
  end

  // Nothing is offered while a branch flushes the buffer
  assign instr_valid_o = avail & ~fetch_ctrl_i.pc_set;
  assign consume       = instr_valid_o & id_ready_i;

  always_comb begin
    instr_o.instr      = compr ? {16'h0000, hw_lo} : {hw_hi, hw_lo};
    instr_o.addr       = addr_q;
    instr_o.compressed = compr;
    // Error of either word that gives the instruction a halfword
    instr_o.bus_err    = buf_q[0].bus_err | (~compr & hptr_q & buf_q[1].bus_err);
  end

  ////////////////////////////////////////////////////////////////////
  // FIFO bookkeeping
  ////////////////////////////////////////////////////////////////////

  // Entry 0 is used up unless a compressed instruction takes its low half
  assign pop    = consume & (hptr_q | ~compr);
  assign push   = rvalid_i & ~fetch_ctrl_i.pc_set;
  assign wr_idx = cnt_q - {1'b0, pop};

  // Words held plus words on the way must fit in the buffer
  assign fill = {1'b0, cnt_q} + {1'b0, outst_cnt_i};

  always_comb begin
    if (fetch_ctrl_i.pc_set) begin
      // The buffer empties now, so only the read limit applies
      fetch_room_o = (outst_cnt_i < `FETCH_MAX_OUTST);
    end else begin
      fetch_room_o = (fill < `FETCH_BUF_WORDS) && (outst_cnt_i < `FETCH_MAX_OUTST);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q  <= 2'd0;
      hptr_q <= 1'b0;
      addr_q <= '0;
    end else if (fetch_ctrl_i.pc_set) begin
      // Bit 1 of the target selects the starting halfword
      cnt_q  <= 2'd0;
      hptr_q <= fetch_ctrl_i.branch_addr[1];
      addr_q <= fetch_ctrl_i.branch_addr;
    end else begin
      cnt_q <= cnt_q + {1'b0, push} - {1'b0, pop};
      if (consume) begin
        // A compressed instruction flips the halfword, a full one keeps it
        hptr_q <= compr ? ~hptr_q : hptr_q;
        addr_q <= addr_q + (compr ? `FETCH_ADDR_W'd2 : `FETCH_ADDR_W'd4);
      end
    end
  end

  // Word storage shifts down on a pop and writes behind the last entry
  always_ff @(posedge clk) begin
    if (pop) begin
      for (int i = 0; i < `FETCH_BUF_WORDS - 1; i++) begin
        buf_q[i] <= buf_q[i+1];
      end
    end
    if (push) begin
      buf_q[wr_idx] <= resp_i;
    end
  end

endmodule

//--- hw/outstanding_counter.sv
//////////////////////////////////////////////////////////////////////
// Tracks granted reads and drops the responses that belong to the
// stream before a branch. Memory must answer strictly in order
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module outstanding_counter (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       mem_req_i,
  input  logic       mem_gnt_i,
  input  logic       mem_rvalid_i,
  input  logic       pc_set_i,
  output logic [1:0] outst_cnt_o,
  output logic       rvalid_gated_o
);

  logic [1:0] outst_q;
  // Responses still to be thrown away after a branch
  logic [1:0] flush_q;
  logic       accept;
  logic       drop;

  assign accept = mem_req_i & mem_gnt_i;
  assign drop   = mem_rvalid_i & (flush_q != 2'd0);

  // A response in the branch cycle is stale as well
  assign rvalid_gated_o = mem_rvalid_i & (flush_q == 2'd0) & ~pc_set_i;
  assign outst_cnt_o    = outst_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outst_q <= 2'd0;
      flush_q <= 2'd0;
    end else begin
      // Grant and response in one cycle leave the count as it is
      case ({accept, mem_rvalid_i})
        2'b10:   outst_q <= outst_q + 2'd1;
        2'b01:   outst_q <= outst_q - 2'd1;
        default: outst_q <= outst_q;
      endcase
      // Every read in flight at the branch is stale
      if (pc_set_i) begin
        flush_q <= outst_q - {1'b0, mem_rvalid_i};
      end else if (drop) begin
        flush_q <= flush_q - 2'd1;
      end
    end
  end

endmodule

//--- hw/prefetch_fsm.sv
//////////////////////////////////////////////////////////////////////
// Word-aligned read issue. A branch request follows fetch_room_i too,
// so it waits in PF_BRANCH_PEND when two reads are still in flight
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "fetch_defines.svh"

module prefetch_fsm
  import fetch_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst_n,
  input  fetch_ctrl_t              fetch_ctrl_i,
  input  logic                     fetch_room_i,
  input  logic                     mem_gnt_i,
  output logic                     mem_req_o,
  output logic [`FETCH_ADDR_W-1:0] mem_addr_o
);

  prefetch_state_e          state_q, state_n;
  // Address of the next word to request
  logic [`FETCH_ADDR_W-1:0] addr_q, addr_n;
  logic [`FETCH_ADDR_W-1:0] target;

  // Branch target with the halfword offset dropped
  assign target = {fetch_ctrl_i.branch_addr[`FETCH_ADDR_W-1:2], 2'b00};

  always_comb begin
    state_n    = state_q;
    addr_n     = addr_q;
    mem_req_o  = 1'b0;
    mem_addr_o = addr_q;
    if (fetch_ctrl_i.pc_set) begin
      // The target goes out in the same cycle as the branch
      mem_req_o  = fetch_room_i;
      mem_addr_o = target;
      if (fetch_room_i && mem_gnt_i) begin
        addr_n  = target + `FETCH_ADDR_W'd4;
        state_n = PF_RUN;
      end else begin
        addr_n  = target;
        state_n = PF_BRANCH_PEND;
      end
    end else begin
      case (state_q)
        PF_IDLE: begin
          // Resume from the held address once fetching is wanted again
          if (fetch_ctrl_i.instr_req) state_n = PF_RUN;
        end
        PF_RUN, PF_BRANCH_PEND: begin
          if (!fetch_ctrl_i.instr_req) begin
            state_n = PF_IDLE;
          end else begin
            mem_req_o = fetch_room_i;
            if (fetch_room_i && mem_gnt_i) begin
              addr_n  = addr_q + `FETCH_ADDR_W'd4;
              state_n = PF_RUN;
            end
          end
        end
        default: state_n = PF_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= PF_IDLE;
      addr_q  <= '0;
    end else begin
      state_q <= state_n;
      addr_q  <= addr_n;
    end
  end

endmodule

//--- hw/fetch_pkg.sv
//////////////////////////////////////////////////////////////////////
// Types for the fetch front end. Instruction data is always 32 bits
//////////////////////////////////////////////////////////////////////

`include "fetch_defines.svh"

package fetch_pkg;

  // Command from the controller, pc_set is a single-cycle pulse
  typedef struct packed {
    logic                     instr_req;
    logic                     pc_set;
    logic [`FETCH_ADDR_W-1:0] branch_addr;
  } fetch_ctrl_t;

  // One word returned by instruction memory
  typedef struct packed {
    logic [31:0] rdata;
    logic        bus_err;
  } inst_resp_t;

  // Instruction handed to decode
  // A compressed instruction sits in the low half with zeros above
  typedef struct packed {
    logic [31:0]              instr;
    logic [`FETCH_ADDR_W-1:0] addr;
    logic                     compressed;
    logic                     bus_err;
  } instr_out_t;

  // Prefetch states
  typedef enum logic [1:0] {PF_IDLE, PF_RUN, PF_BRANCH_PEND} prefetch_state_e;

endpackage

//--- include/fetch_defines.svh
//////////////////////////////////////////////////////////////////////
// Sizes shared by the fetch front end. The buffer depth and the read
// limit are sized as a pair, so raising only one can overflow the FIFO
//////////////////////////////////////////////////////////////////////

`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// Instruction address width in bits
`define FETCH_ADDR_W 32

// Depth of the alignment buffer in 32-bit words
`define FETCH_BUF_WORDS 3

// Most memory reads that may be granted without a response
`define FETCH_MAX_OUTST 2

`endif
